// File: source/hart_sched_pkg.sv
// ----------------------------------------------------------
// hart scheduling package
// command opcodes for the hart state unit and the hart id
// width helper shared by every block of the scheduler
// ----------------------------------------------------------

package hart_sched_pkg;

    // hart state unit command set, 2 bit encoding
    typedef enum logic [1:0] {
        HSTU_NOP      = 2'd0, // no change
        HSTU_START    = 2'd1, // activate hart
        HSTU_STOP     = 2'd2, // deactivate hart
        HSTU_SET_PRIM = 2'd3  // move primary to an active hart
    } hstu_op_e;

    // bits needed to name one of harts, never below 1
    function automatic int hart_id_width(input int harts);
        int w;
        w = 1;
        while ((1 << w) < harts) begin
            w = w + 1; // ceil(log2) by search
        end
        return w;
    endfunction

endpackage

// File: source/minor_hart_sel.sv
// ----------------------------------------------------------
// minor hart selector
// picks the lowest-index hart out of the minor hart mask and
// returns it one-hot, zero when no minor hart is active
// ----------------------------------------------------------

module minor_hart_sel #(
    parameter int num_harts = 4
) (
    input  logic [num_harts-1:0] minor_hstate,
    output logic [num_harts-1:0] one_hot_hstate
);

    localparam int hid_w = hart_sched_pkg::hart_id_width(num_harts);

    logic [hid_w-1:0] low_idx; // index of lowest set bit
    logic             found;   // any minor hart present

    // scan from the top so the lowest index wins
    always_comb begin
        low_idx = '0;
        found   = 1'b0;
        for (int i = num_harts - 1; i >= 0; i--) begin
            if (minor_hstate[i]) begin
                low_idx = hid_w'(i);
                found   = 1'b1;
            end
        end
    end

    // decode back to a mask
    assign one_hot_hstate = found ? (num_harts'(1) << low_idx) : '0;

endmodule

// File: source/hart_switch.sv
// ----------------------------------------------------------
// hart switch
// per-cycle issue mask selection from hart state, decode
// hints and cache status, plus stall/flush on cache misses
// and the issue history used by the next selection
// ----------------------------------------------------------

module hart_switch #(
    parameter int num_harts = 4
) (
    input  logic                 clk,
    input  logic                 rst,

    // ID stage
    input  logic                 id_hkill,   // kill request from decode
    input  logic [hart_sched_pkg::hart_id_width(num_harts)-1:0] id_set_hid,
    input  logic                 is_branch,  // conditional branch in ID
    input  logic                 is_load,    // load in ID
    input  logic [hart_sched_pkg::hart_id_width(num_harts)-1:0] if_hart_id,

    // cache status
    input  logic                 i_cache_miss,
    input  logic                 d_cache_miss,

    // from hart state unit
    input  logic [num_harts-1:0] prim_hstate,
    input  logic [num_harts-1:0] acti_hstate,

    output logic [num_harts-1:0] hart_issue_hstate,
    output logic                 hart_ic_stall,
    output logic                 hart_dc_stall,
    output logic                 hart_ic_flush,
    output logic                 hart_dc_flush,
    output logic                 pipe_stall   // back-pressure to state unit
);

    logic [num_harts-1:0] minor_hstate;   // active but not primary
    logic [num_harts-1:0] one_hot_hstate; // lowest minor hart
    logic [num_harts-1:0] ids_hstate;     // decoded ID hart
    logic [num_harts-1:0] set_hstate;     // decoded kill target
    logic [num_harts-1:0] rot_hstate;     // round robin candidate
    logic [num_harts-1:0] issue_hstate;   // last issued mask
    logic                 issue_minor;
    logic                 issue_twice;
    logic                 no_more_active;
    logic                 id_prim;
    logic                 kill_prim;
    logic                 all_active;

    assign minor_hstate   = acti_hstate & ~prim_hstate;
    assign no_more_active = (minor_hstate == '0);
    assign all_active     = (acti_hstate == {num_harts{1'b1}});

    assign ids_hstate = num_harts'(1) << if_hart_id;
    assign set_hstate = num_harts'(1) << id_set_hid;
    assign id_prim    = (ids_hstate == prim_hstate);
    assign kill_prim  = id_hkill & (set_hstate == prim_hstate);

    // only the primary left -> nobody to switch to, so stall
    assign hart_ic_stall = no_more_active & i_cache_miss;
    assign hart_dc_stall = no_more_active & d_cache_miss;
    assign hart_ic_flush = ~no_more_active & i_cache_miss; // switch away instead
    assign hart_dc_flush = ~no_more_active & d_cache_miss;
    assign pipe_stall    = hart_ic_stall | hart_dc_stall;

    minor_hart_sel #(
        .num_harts (num_harts)
    ) minor_hart_sel_i (
        .minor_hstate   (minor_hstate),
        .one_hot_hstate (one_hot_hstate)
    );

    // cyclic right rotate, empty history starts at top hart
    always_comb begin
        if (issue_hstate == '0) begin
            rot_hstate = {1'b1, {(num_harts-1){1'b0}}};
        end else begin
            rot_hstate = {issue_hstate[0], issue_hstate[num_harts-1:1]};
        end
    end

    // issue priority chain, first match wins
    always_comb begin
        if (pipe_stall) begin
            hart_issue_hstate = issue_hstate;                // hold
        end else if (kill_prim) begin
            hart_issue_hstate = one_hot_hstate;
        end else if (all_active) begin
            hart_issue_hstate = rot_hstate;                  // fine-grained interleave
        end else if (no_more_active) begin
            hart_issue_hstate = prim_hstate;
        end else if ((is_branch | is_load) & id_prim) begin
            hart_issue_hstate = one_hot_hstate;              // hide branch/load shadow
        end else if (issue_minor & issue_twice) begin
            hart_issue_hstate = minor_hstate;
        end else if (issue_minor) begin
            hart_issue_hstate = minor_hstate & ~issue_hstate; // other minors
        end else begin
            hart_issue_hstate = prim_hstate;
        end
    end

    // issue history, updated every edge
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_hstate <= '0;
            issue_minor  <= 1'b0;
            issue_twice  <= 1'b0;
        end else begin
            issue_hstate <= hart_issue_hstate;
            // load on primary, or branch with exactly one hart idle
            issue_minor  <= (is_load & id_prim)
                          | (is_branch & id_prim
                             & ($countones(acti_hstate) == num_harts - 1));
            issue_twice  <= is_load & $onehot(minor_hstate); // single minor hart
        end
    end

endmodule

// File: source/hart_state_unit.sv
// ----------------------------------------------------------
// hart state unit
// active and primary hart registers, changed by start, stop
// and set-primary commands taken over a valid/ready port
// ----------------------------------------------------------

module hart_state_unit #(
    parameter int num_harts = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  hart_sched_pkg::hstu_op_e cmd_op,
    input  logic [hart_sched_pkg::hart_id_width(num_harts)-1:0] cmd_hid,
    input  logic                     pipe_stall,  // pipeline stalled on a miss
    output logic [num_harts-1:0]     acti_hstate,
    output logic [num_harts-1:0]     prim_hstate  // one-hot or zero
);

    logic                 cmd_acc;    // handshake this cycle
    logic [num_harts-1:0] hid_mask;   // decoded target hart
    logic [num_harts-1:0] remain;     // active set after a stop
    logic [num_harts-1:0] remain_low; // new primary candidate

    assign cmd_ready = ~pipe_stall;   // only back-pressure source
    assign cmd_acc   = cmd_valid & cmd_ready;
    assign hid_mask  = num_harts'(1) << cmd_hid;

    assign remain     = acti_hstate & ~hid_mask;
    assign remain_low = remain & (~remain + num_harts'(1)); // isolate lowest bit

    always_ff @(posedge clk) begin
        if (rst) begin
            acti_hstate <= num_harts'(1); // hart 0 boots
            prim_hstate <= num_harts'(1);
        end else if (cmd_acc) begin
            case (cmd_op)
                hart_sched_pkg::HSTU_START: begin
                    acti_hstate <= acti_hstate | hid_mask;
                    if (acti_hstate == '0) begin
                        prim_hstate <= hid_mask; // first hart up becomes primary
                    end
                end
                hart_sched_pkg::HSTU_STOP: begin
                    acti_hstate <= remain;
                    if (prim_hstate == hid_mask) begin
                        prim_hstate <= remain_low; // zero when nothing left
                    end
                end
                hart_sched_pkg::HSTU_SET_PRIM: begin
                    if ((acti_hstate & hid_mask) != '0) begin
                        prim_hstate <= hid_mask;
                    end
                end
                default: begin
                    // nop, hold state
                end
            endcase
        end
    end

endmodule

// File: source/hart_sched_top.sv
// ----------------------------------------------------------
// hart scheduler top
// state unit feeding the hart switch, miss stall fed back
// as command back-pressure
// ----------------------------------------------------------

module hart_sched_top #(
    parameter int num_harts = 4
) (
    input  logic                     clk,
    input  logic                     rst,

    // command port
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  hart_sched_pkg::hstu_op_e cmd_op,
    input  logic [hart_sched_pkg::hart_id_width(num_harts)-1:0] cmd_hid,

    // decode hints and kill
    input  logic                     is_branch,
    input  logic                     is_load,
    input  logic [hart_sched_pkg::hart_id_width(num_harts)-1:0] if_hart_id,
    input  logic                     id_hkill,
    input  logic [hart_sched_pkg::hart_id_width(num_harts)-1:0] id_set_hid,

    // cache status
    input  logic                     i_cache_miss,
    input  logic                     d_cache_miss,

    output logic [num_harts-1:0]     hart_issue_hstate,
    output logic                     hart_ic_stall,
    output logic                     hart_dc_stall,
    output logic                     hart_ic_flush,
    output logic                     hart_dc_flush,
    output logic [num_harts-1:0]     acti_hstate,
    output logic [num_harts-1:0]     prim_hstate
);

    logic pipe_stall; // switch -> state unit

    hart_state_unit #(
        .num_harts (num_harts)
    ) hart_state_unit_i (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_op      (cmd_op),
        .cmd_hid     (cmd_hid),
        .pipe_stall  (pipe_stall),
        .acti_hstate (acti_hstate),
        .prim_hstate (prim_hstate)
    );

    hart_switch #(
        .num_harts (num_harts)
    ) hart_switch_i (
        .clk               (clk),
        .rst               (rst),
        .id_hkill          (id_hkill),
        .id_set_hid        (id_set_hid),
        .is_branch         (is_branch),
        .is_load           (is_load),
        .if_hart_id        (if_hart_id),
        .i_cache_miss      (i_cache_miss),
        .d_cache_miss      (d_cache_miss),
        .prim_hstate       (prim_hstate),
        .acti_hstate       (acti_hstate),
        .hart_issue_hstate (hart_issue_hstate),
        .hart_ic_stall     (hart_ic_stall),
        .hart_dc_stall     (hart_dc_stall),
        .hart_ic_flush     (hart_ic_flush),
        .hart_dc_flush     (hart_dc_flush),
        .pipe_stall        (pipe_stall)
    );

endmodule

// File: verification/hart_sched_properties.sv
// ----------------------------------------------------------
// hart scheduler properties
// state mask shape, back-pressure and stall/flush exclusion
// ----------------------------------------------------------

module hart_sched_properties #(
    parameter int num_harts = 4
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 cmd_ready,
    input logic                 hart_ic_stall,
    input logic                 hart_dc_stall,
    input logic                 hart_ic_flush,
    input logic                 hart_dc_flush,
    input logic [num_harts-1:0] acti_hstate,
    input logic [num_harts-1:0] prim_hstate
);

    prim_one_hot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(prim_hstate))
        else $error("primary mask has more than one hart");

    prim_in_acti: assert property (@(posedge clk) disable iff (rst)
        (prim_hstate & ~acti_hstate) == '0)
        else $error("primary hart is not active");

    ready_vs_stall: assert property (@(posedge clk) disable iff (rst)
        cmd_ready == !(hart_ic_stall || hart_dc_stall))
        else $error("cmd_ready does not track the stall outputs");

    stall_xor_flush: assert property (@(posedge clk) disable iff (rst)
        !(hart_ic_stall && hart_ic_flush) && !(hart_dc_stall && hart_dc_flush))
        else $error("stall and flush raised together on one side");

endmodule

bind hart_sched_top hart_sched_properties #(.num_harts(num_harts)) props_i (
    .clk           (clk),
    .rst           (rst),
    .cmd_ready     (cmd_ready),
    .hart_ic_stall (hart_ic_stall),
    .hart_dc_stall (hart_dc_stall),
    .hart_ic_flush (hart_ic_flush),
    .hart_dc_flush (hart_dc_flush),
    .acti_hstate   (acti_hstate),
    .prim_hstate   (prim_hstate)
);

// File: verification/hart_sched_tb.sv
// ----------------------------------------------------------
// hart scheduler testbench
// directed and LFSR random stimulus on the command port,
// decode hints and cache status, checked every cycle
// against a reference model of the issue and state rules
// ----------------------------------------------------------

module hart_sched_tb;

    localparam int N           = 4;
    localparam int HW          = $clog2(N);
    localparam int PERIOD      = 40;
    localparam int HALF        = PERIOD / 2;
    localparam int RST_CYCLES  = 5;
    localparam int DIR_CYCLES  = 100;  // upper bound of the directed part
    localparam int RAND_CYCLES = 3000;

    logic                     clk;
    logic                     rst;
    logic                     cmd_valid;
    logic                     cmd_ready;
    hart_sched_pkg::hstu_op_e cmd_op;
    logic [HW-1:0]            cmd_hid;
    logic                     is_branch;
    logic                     is_load;
    logic [HW-1:0]            if_hart_id;
    logic                     id_hkill;
    logic [HW-1:0]            id_set_hid;
    logic                     i_cache_miss;
    logic                     d_cache_miss;
    logic [N-1:0]             hart_issue_hstate;
    logic                     hart_ic_stall;
    logic                     hart_dc_stall;
    logic                     hart_ic_flush;
    logic                     hart_dc_flush;
    logic [N-1:0]             acti_hstate;
    logic [N-1:0]             prim_hstate;

    logic [31:0]  lfsr_state;
    logic [N-1:0] sh_acti;      // shadow active mask
    logic [N-1:0] sh_prim;      // shadow primary
    logic [N-1:0] sh_hist;      // last issued mask
    logic         sh_minor;
    logic         sh_twice;
    logic         cmd_pending;  // command seen but back-pressured
    int           checks;
    int           errors;

    hart_sched_top #(.num_harts(N)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    // galois form, taps x^32+x^22+x^2+x+1
    function automatic logic rand_bit();
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        return lfsr_state[0];
    endfunction

    function automatic logic [HW-1:0] rand_hid();
        logic [HW-1:0] v;
        for (int i = 0; i < HW; i++) begin
            v[i] = rand_bit();
        end
        return v;
    endfunction

    function automatic logic [N-1:0] onehot_of(input logic [HW-1:0] hid);
        logic [N-1:0] m;
        m      = '0;
        m[hid] = 1'b1;
        return m;
    endfunction

    // lowest set hart, zero when none
    function automatic logic [N-1:0] lowest_bit(input logic [N-1:0] mask);
        for (int i = 0; i < N; i++) begin
            if (mask[i]) return onehot_of(HW'(i));
        end
        return '0;
    endfunction

    // expected issue mask, rules taken in priority order
    function automatic logic [N-1:0] ref_issue(
        input logic [N-1:0] acti, prim, hist,
        input logic h_minor, h_twice, stall, kill, branch, load,
        input logic [HW-1:0] set_hid, fetch_hid
    );
        logic [N-1:0] minor;
        logic [N-1:0] shifted;
        minor   = acti & ~prim;
        shifted = (hist >> 1) | (hist << (N - 1)); // bit 0 comes back at the top
        if (hist == '0) shifted = onehot_of(HW'(N - 1)); // empty history starts at top hart
        if (stall) return hist;
        if (kill && prim == onehot_of(set_hid)) return lowest_bit(minor);
        if (&acti) return shifted;
        if (minor == '0) return prim;
        if ((branch || load) && prim == onehot_of(fetch_hid)) return lowest_bit(minor);
        if (h_minor && h_twice) return minor;
        if (h_minor) return minor & ~hist;
        return prim;
    endfunction

    task automatic apply_cmd(input hart_sched_pkg::hstu_op_e op, input logic [HW-1:0] hid);
        logic [N-1:0] m;
        m = onehot_of(hid);
        case (op)
            hart_sched_pkg::HSTU_START: begin
                if (sh_acti == '0) sh_prim = m; // first hart up
                sh_acti = sh_acti | m;
            end
            hart_sched_pkg::HSTU_STOP: begin
                if (sh_prim == m) sh_prim = lowest_bit(sh_acti & ~m);
                sh_acti = sh_acti & ~m;
            end
            hart_sched_pkg::HSTU_SET_PRIM: begin
                if ((sh_acti & m) != '0) sh_prim = m; // only active harts
            end
            default: ;
        endcase
    endtask

    task automatic check_mask(input string name, input logic [N-1:0] got, input logic [N-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic send_cmd(input hart_sched_pkg::hstu_op_e op, input logic [HW-1:0] hid);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_hid   = hid;
        @(negedge clk);
        while (cmd_pending) @(negedge clk); // held through a stall
        cmd_valid = 1'b0;
    endtask

    // comparing process, samples one unit before each rising edge
    initial begin
        logic [N-1:0] minor;
        logic [N-1:0] exp_issue;
        logic         exp_ic_stall;
        logic         exp_dc_stall;
        logic         exp_stall;
        logic         prim_id;
        forever begin
            @(negedge clk);
            #(HALF - 1);
            if (rst) begin
                sh_acti     = onehot_of('0);
                sh_prim     = onehot_of('0);
                sh_hist     = '0;
                sh_minor    = 1'b0;
                sh_twice    = 1'b0;
                cmd_pending = 1'b0;
            end else begin
                minor        = sh_acti & ~sh_prim;
                exp_ic_stall = (minor == '0) && i_cache_miss; // no hart to switch to
                exp_dc_stall = (minor == '0) && d_cache_miss;
                exp_stall    = exp_ic_stall || exp_dc_stall;
                exp_issue    = ref_issue(sh_acti, sh_prim, sh_hist, sh_minor, sh_twice,
                                         exp_stall, id_hkill, is_branch, is_load,
                                         id_set_hid, if_hart_id);
                check_mask("hart_issue_hstate", hart_issue_hstate, exp_issue);
                check_bit("hart_ic_stall", hart_ic_stall, exp_ic_stall);
                check_bit("hart_dc_stall", hart_dc_stall, exp_dc_stall);
                check_bit("hart_ic_flush", hart_ic_flush, (minor != '0) && i_cache_miss);
                check_bit("hart_dc_flush", hart_dc_flush, (minor != '0) && d_cache_miss);
                check_bit("cmd_ready", cmd_ready, !exp_stall);
                check_mask("acti_hstate", acti_hstate, sh_acti);
                check_mask("prim_hstate", prim_hstate, sh_prim);
                // history for the next cycle
                prim_id  = (sh_prim == onehot_of(if_hart_id));
                sh_minor = prim_id && (is_load || (is_branch && $countones(sh_acti) == N - 1));
                sh_twice = is_load && $countones(minor) == 1;
                sh_hist  = exp_issue;
                cmd_pending = cmd_valid && exp_stall;
                if (cmd_valid && !exp_stall) apply_cmd(cmd_op, cmd_hid);
            end
        end
    end

    // watchdog
    initial begin
        #((RST_CYCLES + DIR_CYCLES + RAND_CYCLES + 100) * PERIOD);
        $display("timeout: stimulus did not complete in the expected time");
        $display("Test failed");
        $finish;
    end

    initial begin
        lfsr_state   = 32'h8e55e878;
        checks       = 0;
        errors       = 0;
        cmd_pending  = 1'b0;
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd_op       = hart_sched_pkg::HSTU_NOP;
        cmd_hid      = '0;
        is_branch    = 1'b0;
        is_load      = 1'b0;
        if_hart_id   = '0;
        id_hkill     = 1'b0;
        id_set_hid   = '0;
        i_cache_miss = 1'b0;
        d_cache_miss = 1'b0;
        step(RST_CYCLES);
        rst = 1'b0;
        step(2);
        // miss with only the primary up: stall, command held
        i_cache_miss = 1'b1;
        cmd_valid    = 1'b1;
        cmd_op       = hart_sched_pkg::HSTU_START;
        cmd_hid      = HW'(1);
        step(3);
        i_cache_miss = 1'b0;
        step(1);                  // accepted here
        cmd_valid    = 1'b0;
        d_cache_miss = 1'b1;      // two harts now, flush instead
        step(2);
        d_cache_miss = 1'b0;
        // all four up, round robin
        send_cmd(hart_sched_pkg::HSTU_START, HW'(2));
        send_cmd(hart_sched_pkg::HSTU_START, HW'(3));
        step(8);
        // stop the primary, then shrink to a single hart
        send_cmd(hart_sched_pkg::HSTU_STOP, HW'(0));
        send_cmd(hart_sched_pkg::HSTU_STOP, HW'(2));
        send_cmd(hart_sched_pkg::HSTU_STOP, HW'(3));
        step(4);
        send_cmd(hart_sched_pkg::HSTU_START, HW'(3));
        id_hkill   = 1'b1;        // kill aimed at primary hart 1
        id_set_hid = HW'(1);
        step(1);
        id_hkill   = 1'b0;
        step(2);
        // load and branch on the primary
        if_hart_id = HW'(1);
        is_load    = 1'b1;
        step(1);
        is_load    = 1'b0;
        step(3);
        send_cmd(hart_sched_pkg::HSTU_START, HW'(2));
        is_load    = 1'b1;
        step(1);
        is_load    = 1'b0;
        step(3);
        is_branch  = 1'b1;
        step(1);
        is_branch  = 1'b0;
        step(3);
        send_cmd(hart_sched_pkg::HSTU_SET_PRIM, HW'(3));
        send_cmd(hart_sched_pkg::HSTU_SET_PRIM, HW'(0)); // inactive, ignored
        step(2);
        // random phase
        repeat (RAND_CYCLES) begin
            if (!cmd_pending) begin
                cmd_valid = rand_bit();
                cmd_op    = hart_sched_pkg::hstu_op_e'({rand_bit(), rand_bit()});
                cmd_hid   = rand_hid();
            end
            is_branch    = rand_bit() & rand_bit();
            is_load      = rand_bit() & rand_bit();
            if_hart_id   = rand_hid();
            id_hkill     = rand_bit() & rand_bit() & rand_bit();
            id_set_hid   = rand_hid();
            i_cache_miss = rand_bit() & rand_bit() & rand_bit();
            d_cache_miss = rand_bit() & rand_bit() & rand_bit();
            step(1);
        end
        step(2);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
source/hart_sched_pkg.sv
source/minor_hart_sel.sv
source/hart_switch.sv
source/hart_state_unit.sv
source/hart_sched_top.sv
verification/hart_sched_properties.sv
verification/hart_sched_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the hart scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module hart_sched_tb \
        -f sim.f -o hart_sched_sim; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/hart_sched_sim)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
